// File: vlog.f
source/usb_stream_pkg.sv
source/ulpi_pkg.sv
source/ulpi_phy_model.sv
source/ulpi_link.sv
source/ulpi_loopback_top.sv
tb/ulpi_loopback_chk.sv
tb/ulpi_loopback_tb.sv

// File: Makefile
VERILATOR  := verilator
TOP        := ulpi_loopback_tb
FILELIST   := vlog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
RUN_ARGS   := +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Testbench passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/ulpi_loopback_tb.sv
module ulpi_loopback_tb
  import usb_stream_pkg::*, ulpi_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 10;
  localparam int IDLE_CYCLES = 20;
  localparam int HOST_PACKETS = 12;
  localparam int WIRE_PACKETS = 12;
  localparam int REG_WRITES = 4;
  localparam int WATCHDOG_CYCLES =
    (HOST_PACKETS + WIRE_PACKETS + REG_WRITES) * 40 + 2 * LINE_STATE_PERIOD;

  logic             clock;
  logic             reset;
  usb_stream_t      host_tx;
  logic             host_tx_ready;
  usb_stream_t      host_rx;
  logic             reg_write;
  ulpi_reg_addr_t   reg_addr;
  usb_byte_t        reg_data;
  logic             reg_write_done;
  ulpi_line_state_t line_state;
  usb_stream_t      wire_in;
  logic             wire_in_ready;
  usb_stream_t      wire_out;
  logic             wire_out_ready;
  ulpi_line_state_t wire_line_state;
  ulpi_reg_addr_t   phy_reg_addr;
  usb_byte_t        phy_reg_data;

  int seed = 32'h21a9_05e3;
  int gap_seed;

  // Expected beats as {last, data}
  logic [8:0] wire_exp[$];
  logic [8:0] rx_exp[$];
  logic [8:0] wire_beat;
  logic [8:0] rx_beat;

  ulpi_reg_addr_t   next_addr;
  usb_byte_t        next_data;
  ulpi_line_state_t next_line_state;

  ulpi_loopback_top ulpi_loopback_top_i (
    .clock             (clock),
    .reset             (reset),
    .host_tx_i         (host_tx),
    .host_tx_ready_o   (host_tx_ready),
    .host_rx_o         (host_rx),
    .reg_write_i       (reg_write),
    .reg_addr_i        (reg_addr),
    .reg_data_i        (reg_data),
    .reg_write_done_o  (reg_write_done),
    .line_state_o      (line_state),
    .wire_in_i         (wire_in),
    .wire_in_ready_o   (wire_in_ready),
    .wire_out_o        (wire_out),
    .wire_out_ready_i  (wire_out_ready),
    .wire_line_state_i (wire_line_state),
    .phy_reg_addr_o    (phy_reg_addr),
    .phy_reg_data_o    (phy_reg_data)
  );

  bind ulpi_loopback_top ulpi_loopback_chk ulpi_loopback_chk_i (
    .clock            (clock),
    .reset            (reset),
    .link_bus_i       (link_bus),
    .phy_bus_i        (phy_bus),
    .host_tx_i        (host_tx_i),
    .host_tx_ready_i  (host_tx_ready_o),
    .wire_out_i       (wire_out_o),
    .wire_out_ready_i (wire_out_ready_i)
  );

  always #4 clock = ~clock;

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic report_problem(input string reason);
    $display("%s", reason);
    abort_run();
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("ERROR at %0d ns: %s expected %0h got %0h", $time, name, expected, actual);
    abort_run();
  endtask

  task automatic send_host_packet(input int len);
    usb_byte_t pkt_byte;
    for (int i = 0; i < len; i++) begin
      pkt_byte = 8'($random(seed));
      // On the wire the PID byte carries its complement in the upper nibble
      if (i == 0) begin
        wire_exp.push_back({i == len - 1, ~pkt_byte[3:0], pkt_byte[3:0]});
      end else begin
        wire_exp.push_back({i == len - 1, pkt_byte});
      end
      host_tx.valid = 1'b1;
      host_tx.last = (i == len - 1);
      host_tx.data = pkt_byte;
      while (!host_tx_ready) @(negedge clock);
      @(negedge clock);
    end
    host_tx.valid = 1'b0;
    host_tx.last = 1'b0;
    @(negedge clock);
  endtask

  task automatic send_wire_packet(input int len);
    usb_byte_t pkt_byte;
    for (int i = 0; i < len; i++) begin
      pkt_byte = 8'($random(seed));
      rx_exp.push_back({i == len - 1, pkt_byte});
      wire_in.valid = 1'b1;
      wire_in.last = (i == len - 1);
      wire_in.data = pkt_byte;
      while (!wire_in_ready) @(negedge clock);
      @(negedge clock);
    end
    wire_in.valid = 1'b0;
    wire_in.last = 1'b0;
    @(negedge clock);
  endtask

  task automatic write_phy_reg(input ulpi_reg_addr_t addr, input usb_byte_t data);
    reg_write = 1'b1;
    reg_addr = addr;
    reg_data = data;
    @(negedge clock);
    reg_write = 1'b0;
    while (!reg_write_done) @(negedge clock);
    assert ({phy_reg_addr, phy_reg_data} == {addr, data})
      else report_mismatch("{phy_reg_addr_o,phy_reg_data_o}", 32'({addr, data}),
                           32'({phy_reg_addr, phy_reg_data}));
    @(negedge clock);
    // Done is a single-cycle pulse
    assert (!reg_write_done)
      else report_mismatch("reg_write_done_o", 0, 32'(reg_write_done));
  endtask

  task automatic wait_for_drain();
    while (wire_exp.size() != 0 || rx_exp.size() != 0) @(negedge clock);
  endtask

  // Random gaps on the wire side ready
  always @(negedge clock) begin
    if (reset) begin
      wire_out_ready = 1'b1;
    end else begin
      wire_out_ready = ($random(gap_seed) & 3) != 0;
    end
  end

  always @(posedge clock) begin
    if (!reset && wire_out.valid && wire_out_ready) begin
      if (wire_exp.size() == 0) begin
        report_problem("wire_out_o delivered a byte that no host packet produced");
      end else begin
        wire_beat = wire_exp.pop_front();
        assert ({wire_out.last, wire_out.data} == wire_beat)
          else report_mismatch("wire_out_o {last,data}", 32'(wire_beat),
                               32'({wire_out.last, wire_out.data}));
      end
    end
  end

  always @(posedge clock) begin
    if (!reset && host_rx.valid) begin
      if (rx_exp.size() == 0) begin
        report_problem("host_rx_o delivered a byte that no wire packet produced");
      end else begin
        rx_beat = rx_exp.pop_front();
        assert ({host_rx.last, host_rx.data} == rx_beat)
          else report_mismatch("host_rx_o {last,data}", 32'(rx_beat),
                               32'({host_rx.last, host_rx.data}));
      end
    end
  end

  always @(negedge clock) begin
    if (ulpi_loopback_top_i.ulpi_loopback_chk_i.assert_failures != 0) begin
      report_problem("A bound ULPI protocol assertion failed");
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    report_problem("Watchdog expired before all tests finished");
  end

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    host_tx = '0;
    wire_in = '0;
    reg_write = 1'b0;
    reg_addr = '0;
    reg_data = '0;
    wire_out_ready = 1'b1;
    wire_line_state = 2'b01;
    gap_seed = $random(seed);
    repeat (RESET_CYCLES) @(negedge clock);
    reset = 1'b0;

    // Nothing may come out while no stimulus is applied
    repeat (IDLE_CYCLES) begin
      @(negedge clock);
      assert ({host_rx.valid, wire_out.valid, reg_write_done} == 3'b000)
        else report_mismatch("{host_rx_o.valid,wire_out_o.valid,reg_write_done_o}", 0,
                             32'({host_rx.valid, wire_out.valid, reg_write_done}));
    end

    for (int n = 0; n < HOST_PACKETS; n++) begin
      send_host_packet(1 + ($random(seed) & 7));
    end
    wait_for_drain();

    for (int n = 0; n < WIRE_PACKETS; n++) begin
      send_wire_packet(1 + ($random(seed) & 7));
    end
    wait_for_drain();

    for (int n = 0; n < REG_WRITES; n++) begin
      next_addr = 6'($random(seed));
      next_data = 8'($random(seed));
      write_phy_reg(next_addr, next_data);
    end

    next_line_state = 2'($random(seed));
    if (next_line_state == wire_line_state) begin
      next_line_state = ~next_line_state;
    end
    wire_line_state = next_line_state;
    repeat (2 * LINE_STATE_PERIOD) @(negedge clock);
    assert (line_state == next_line_state)
      else report_mismatch("line_state_o", 32'(next_line_state), 32'(line_state));

    if (ulpi_loopback_top_i.ulpi_loopback_chk_i.assert_failures != 0) begin
      report_problem("A bound ULPI protocol assertion failed");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// File: tb/ulpi_loopback_chk.sv
module ulpi_loopback_chk
  import usb_stream_pkg::*, ulpi_pkg::*;
(
  input logic           clock,
  input logic           reset,
  input ulpi_link_bus_t link_bus_i,
  input ulpi_phy_bus_t  phy_bus_i,
  input usb_stream_t    host_tx_i,
  input logic           host_tx_ready_i,
  input usb_stream_t    wire_out_i,
  input logic           wire_out_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // Count of failed properties, polled by the testbench
  int unsigned assert_failures = 0;

  // Bus is released and quiet right after reset
  reset_release: assert property (@(posedge clock)
    $fell(reset) |-> !phy_bus_i.dir && !link_bus_i.stp)
    else begin
      assert_failures++;
      $error("dir or stp high when reset was released");
    end

  stp_outside_dir: assert property (@(posedge clock) disable iff (reset)
    phy_bus_i.dir |-> !link_bus_i.stp)
    else begin
      assert_failures++;
      $error("stp raised while the PHY owns the bus");
    end

  stp_single_cycle: assert property (@(posedge clock) disable iff (reset)
    link_bus_i.stp |=> !link_bus_i.stp)
    else begin
      assert_failures++;
      $error("stp held for more than one cycle");
    end

  // The cycle after a dir change is a turnaround
  turnaround_nxt: assert property (@(posedge clock) disable iff (reset)
    (phy_bus_i.dir != $past(phy_bus_i.dir)) |-> !phy_bus_i.nxt)
    else begin
      assert_failures++;
      $error("nxt high in a turnaround cycle");
    end

  host_tx_hold: assert property (@(posedge clock) disable iff (reset)
    host_tx_i.valid && !host_tx_ready_i |=> host_tx_i.valid && $stable(host_tx_i))
    else begin
      assert_failures++;
      $error("host_tx changed while waiting for ready");
    end

  wire_out_hold: assert property (@(posedge clock) disable iff (reset)
    wire_out_i.valid && !wire_out_ready_i |=> wire_out_i.valid && $stable(wire_out_i))
    else begin
      assert_failures++;
      $error("wire_out changed while waiting for ready");
    end

endmodule

// File: source/ulpi_loopback_top.sv
module ulpi_loopback_top
  import usb_stream_pkg::*, ulpi_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  usb_stream_t      host_tx_i,
  output logic             host_tx_ready_o,
  output usb_stream_t      host_rx_o,
  input  logic             reg_write_i,
  input  ulpi_reg_addr_t   reg_addr_i,
  input  usb_byte_t        reg_data_i,
  output logic             reg_write_done_o,
  output ulpi_line_state_t line_state_o,
  input  usb_stream_t      wire_in_i,
  output logic             wire_in_ready_o,
  output usb_stream_t      wire_out_o,
  input  logic             wire_out_ready_i,
  input  ulpi_line_state_t wire_line_state_i,
  output ulpi_reg_addr_t   phy_reg_addr_o,
  output usb_byte_t        phy_reg_data_o
);

  // The two halves of the shared ULPI data bus
  ulpi_link_bus_t link_bus;
  ulpi_phy_bus_t  phy_bus;

  ulpi_link ulpi_link_i (
    .clock            (clock),
    .reset            (reset),
    .host_tx_i        (host_tx_i),
    .host_tx_ready_o  (host_tx_ready_o),
    .host_rx_o        (host_rx_o),
    .reg_write_i      (reg_write_i),
    .reg_addr_i       (reg_addr_i),
    .reg_data_i       (reg_data_i),
    .reg_write_done_o (reg_write_done_o),
    .line_state_o     (line_state_o),
    .phy_bus_i        (phy_bus),
    .link_bus_o       (link_bus)
  );

  ulpi_phy_model ulpi_phy_model_i (
    .clock             (clock),
    .reset             (reset),
    .link_bus_i        (link_bus),
    .phy_bus_o         (phy_bus),
    .wire_in_i         (wire_in_i),
    .wire_in_ready_o   (wire_in_ready_o),
    .wire_out_o        (wire_out_o),
    .wire_out_ready_i  (wire_out_ready_i),
    .wire_line_state_i (wire_line_state_i),
    .phy_reg_addr_o    (phy_reg_addr_o),
    .phy_reg_data_o    (phy_reg_data_o)
  );

endmodule

// File: source/ulpi_link.sv
module ulpi_link
  import usb_stream_pkg::*, ulpi_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  usb_stream_t      host_tx_i,
  output logic             host_tx_ready_o,
  output usb_stream_t      host_rx_o,
  input  logic             reg_write_i,
  input  ulpi_reg_addr_t   reg_addr_i,
  input  usb_byte_t        reg_data_i,
  output logic             reg_write_done_o,
  output ulpi_line_state_t line_state_o,
  input  ulpi_phy_bus_t    phy_bus_i,
  output ulpi_link_bus_t   link_bus_o
);

  typedef enum logic [2:0] {
    L_IDLE,
    L_TX_CMD,
    L_TX_DATA,
    L_TX_STP,
    L_REG_CMD,
    L_REG_DATA,
    L_REG_STP
  } link_state_e;

  link_state_e state_q;
  ulpi_data_t data_q;
  logic stp_q;

  // reg_write_i is a strobe, the request waits here for the bus
  logic reg_pend_q;
  ulpi_reg_addr_t reg_addr_q;
  usb_byte_t reg_data_q;
  logic reg_done_q;

  logic dir_prev_q;
  usb_byte_t held_q;
  logic held_valid_q;
  usb_stream_t rx_q;
  ulpi_line_state_t line_state_q;

  ulpi_rx_cmd_t rx_cmd;
  logic rx_turn;

  assign rx_cmd = phy_bus_i.data;
  assign rx_turn = phy_bus_i.dir != dir_prev_q;

  // Packet bytes go straight from the host stream, so host_tx must not underrun
  assign link_bus_o.data = (state_q == L_TX_DATA) ? host_tx_i.data : data_q;
  assign link_bus_o.stp = stp_q;

  assign host_tx_ready_o = !phy_bus_i.dir && phy_bus_i.nxt &&
                           ((state_q == L_TX_CMD) || (state_q == L_TX_DATA));

  assign host_rx_o = rx_q;
  assign reg_write_done_o = reg_done_q;
  assign line_state_o = line_state_q;

  always_ff @(posedge clock) begin
    if (reg_write_i) begin
      reg_addr_q <= reg_addr_i;
      reg_data_q <= reg_data_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= L_IDLE;
      data_q <= ULPI_CMD_IDLE;
      stp_q <= 1'b0;
      reg_pend_q <= 1'b0;
      reg_done_q <= 1'b0;
    end else begin
      stp_q <= 1'b0;
      reg_done_q <= 1'b0;
      case (state_q)
        L_IDLE: begin
          // Register writes go first, nothing starts while the PHY owns the bus
          if (!phy_bus_i.dir) begin
            if (reg_pend_q) begin
              data_q <= {ULPI_CMD_REG_WRITE, reg_addr_q};
              state_q <= L_REG_CMD;
            end else if (host_tx_i.valid) begin
              data_q <= {ULPI_CMD_TRANSMIT, usb_byte_pid(host_tx_i.data)};
              state_q <= L_TX_CMD;
            end
          end
        end

        L_TX_CMD: begin
          if (phy_bus_i.dir) begin
            data_q <= ULPI_CMD_IDLE;
            state_q <= L_IDLE;
          end else if (phy_bus_i.nxt) begin
            data_q <= ULPI_CMD_IDLE;
            stp_q <= host_tx_i.last;
            state_q <= host_tx_i.last ? L_TX_STP : L_TX_DATA;
          end
        end

        L_TX_DATA: begin
          if (phy_bus_i.nxt && host_tx_i.last) begin
            stp_q <= 1'b1;
            state_q <= L_TX_STP;
          end
        end

        L_REG_CMD: begin
          if (phy_bus_i.dir) begin
            data_q <= ULPI_CMD_IDLE;
            state_q <= L_IDLE;
          end else if (phy_bus_i.nxt) begin
            data_q <= reg_data_q;
            reg_pend_q <= 1'b0;
            state_q <= L_REG_DATA;
          end
        end

        L_REG_DATA: begin
          if (phy_bus_i.nxt) begin
            data_q <= ULPI_CMD_IDLE;
            stp_q <= 1'b1;
            state_q <= L_REG_STP;
          end
        end

        L_REG_STP: begin
          reg_done_q <= 1'b1;
          state_q <= L_IDLE;
        end

        default: begin
          state_q <= L_IDLE;
        end
      endcase

      if (reg_write_i) begin
        reg_pend_q <= 1'b1;
      end
    end
  end

  // Receive side, one byte held back until we know whether it is the last
  always_ff @(posedge clock) begin
    if (reset) begin
      dir_prev_q <= 1'b0;
      held_valid_q <= 1'b0;
      rx_q.valid <= 1'b0;
      rx_q.last <= 1'b0;
      line_state_q <= '0;
    end else begin
      dir_prev_q <= phy_bus_i.dir;
      rx_q.valid <= 1'b0;
      if (phy_bus_i.dir && !rx_turn) begin
        if (phy_bus_i.nxt) begin
          if (held_valid_q) begin
            rx_q.valid <= 1'b1;
            rx_q.last <= 1'b0;
            rx_q.data <= held_q;
          end
          held_q <= phy_bus_i.data;
          held_valid_q <= 1'b1;
        end else begin
          line_state_q <= rx_cmd.line_state;
        end
      end else if (!phy_bus_i.dir && dir_prev_q && held_valid_q) begin
        rx_q.valid <= 1'b1;
        rx_q.last <= 1'b1;
        rx_q.data <= held_q;
        held_valid_q <= 1'b0;
      end
    end
  end

endmodule

// File: source/ulpi_phy_model.sv
module ulpi_phy_model
  import usb_stream_pkg::*, ulpi_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  ulpi_link_bus_t   link_bus_i,
  output ulpi_phy_bus_t    phy_bus_o,
  input  usb_stream_t      wire_in_i,
  output logic             wire_in_ready_o,
  output usb_stream_t      wire_out_o,
  input  logic             wire_out_ready_i,
  input  ulpi_line_state_t wire_line_state_i,
  output ulpi_reg_addr_t   phy_reg_addr_o,
  output usb_byte_t        phy_reg_data_o
);

  ulpi_phy_state_e state_q;

  logic dir_q;
  logic nxt_q;
  ulpi_data_t data_q;

  logic reg_phase_q;
  ulpi_reg_addr_t reg_addr_q;
  usb_byte_t reg_data_q;

  logic send_last_q;
  logic took_q;
  usb_stream_t wire_out_q;

  logic [7:0] lfsr_q;
  logic [LINE_COUNT_W-1:0] line_count_q;
  logic tick_pend_q;

  ulpi_data_t link_data;
  ulpi_rx_cmd_t rx_cmd;
  logic stall;
  logic take;
  logic line_tick;

  assign link_data = link_bus_i.data;
  assign stall = lfsr_q > STALL_THRESHOLD;

  assign rx_cmd.fixed_hi = RX_CMD_FIXED_HI;
  assign rx_cmd.rx_error = 1'b0;
  assign rx_cmd.rx_active = (state_q == PHY_WAIT) || (state_q == PHY_SEND);
  assign rx_cmd.vbus = RX_CMD_VBUS;
  assign rx_cmd.line_state = wire_line_state_i;

  // A link byte is accepted in any transmit cycle with nxt high
  assign take = nxt_q && !dir_q && ((state_q == PHY_WAIT) || (state_q == PHY_RECV));

  assign line_tick = !link_bus_i.stp && (line_count_q == LINE_COUNT_W'(LINE_STATE_PERIOD - 1));

  assign phy_bus_o.data = data_q;
  assign phy_bus_o.dir = dir_q;
  assign phy_bus_o.nxt = nxt_q;

  assign wire_in_ready_o = (state_q == PHY_SEND) && !send_last_q && !stall;
  assign wire_out_o = wire_out_q;

  assign phy_reg_addr_o = reg_addr_q;
  assign phy_reg_data_o = reg_data_q;

  // Fibonacci LFSR, x^8 + x^6 + x^5 + x^4 + 1
  always_ff @(posedge clock) begin
    if (reset) begin
      lfsr_q <= LFSR_SEED;
    end else begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    end
  end

  // Line-state timer, restarted by every stp
  always_ff @(posedge clock) begin
    if (reset || link_bus_i.stp || line_tick) begin
      line_count_q <= '0;
    end else begin
      line_count_q <= line_count_q + 1'b1;
    end
  end

  // A taken byte waits one cycle so that stp can mark it as last
  always_ff @(posedge clock) begin
    if (reset) begin
      took_q <= 1'b0;
      wire_out_q.valid <= 1'b0;
      wire_out_q.last <= 1'b0;
    end else begin
      took_q <= take;
      if (took_q) begin
        wire_out_q.valid <= 1'b1;
        wire_out_q.last <= link_bus_i.stp;
      end else if (wire_out_q.valid && wire_out_ready_i) begin
        wire_out_q.valid <= 1'b0;
      end
    end
    if (take) begin
      wire_out_q.data <= (state_q == PHY_WAIT) ? usb_pid_byte(usb_byte_pid(link_data))
                                               : link_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= PHY_IDLE;
      dir_q <= 1'b0;
      nxt_q <= 1'b0;
      reg_phase_q <= 1'b0;
      send_last_q <= 1'b0;
      tick_pend_q <= 1'b0;
    end else begin
      case (state_q)
        PHY_IDLE: begin
          if (link_data[7:6] == ULPI_CMD_REG_WRITE) begin
            reg_addr_q <= link_data[5:0];
            reg_phase_q <= 1'b0;
            nxt_q <= 1'b1;
            state_q <= PHY_REG_WRITE;
          end else if (link_data[7:4] == ULPI_CMD_TRANSMIT) begin
            // Hold the TX CMD off until the wire side can take bytes
            if (wire_out_ready_i) begin
              nxt_q <= 1'b1;
              state_q <= PHY_WAIT;
            end
          end else if (link_data == ULPI_CMD_IDLE && wire_in_i.valid) begin
            dir_q <= 1'b1;
            state_q <= PHY_WAIT;
          end else if (link_data == ULPI_CMD_IDLE && tick_pend_q) begin
            dir_q <= 1'b1;
            tick_pend_q <= 1'b0;
            state_q <= PHY_LINE;
          end
        end

        PHY_REG_WRITE: begin
          if (link_bus_i.stp) begin
            nxt_q <= 1'b0;
            state_q <= PHY_IDLE;
          end else if (!reg_phase_q) begin
            reg_phase_q <= 1'b1;
            nxt_q <= 1'b1;
          end else if (nxt_q) begin
            reg_data_q <= link_data;
            nxt_q <= 1'b0;
          end
        end

        PHY_WAIT: begin
          // Turnaround before sending, or the PID cycle of a link transmit
          nxt_q <= 1'b0;
          if (dir_q) begin
            data_q <= rx_cmd;
            state_q <= PHY_SEND;
          end else begin
            state_q <= PHY_RECV;
          end
        end

        PHY_SEND: begin
          if (send_last_q) begin
            dir_q <= 1'b0;
            nxt_q <= 1'b0;
            send_last_q <= 1'b0;
            state_q <= PHY_STOP;
          end else if (wire_in_i.valid && wire_in_ready_o) begin
            data_q <= wire_in_i.data;
            nxt_q <= 1'b1;
            send_last_q <= wire_in_i.last;
          end else begin
            data_q <= rx_cmd;
            nxt_q <= 1'b0;
          end
        end

        PHY_RECV: begin
          if (link_bus_i.stp) begin
            nxt_q <= 1'b0;
            state_q <= PHY_IDLE;
          end else begin
            // Only one byte in flight, the output slot must be free
            nxt_q <= !stall && !take && !took_q && (!wire_out_q.valid || wire_out_ready_i);
          end
        end

        PHY_LINE: begin
          data_q <= rx_cmd;
          state_q <= PHY_STAT;
        end

        PHY_STAT: begin
          dir_q <= 1'b0;
          state_q <= PHY_STOP;
        end

        PHY_STOP: begin
          state_q <= PHY_IDLE;
        end

        default: begin
          state_q <= PHY_IDLE;
        end
      endcase

      if (line_tick) begin
        tick_pend_q <= 1'b1;
      end
    end
  end

endmodule

// File: source/ulpi_pkg.sv
package ulpi_pkg;

  typedef logic [7:0] ulpi_data_t;
  typedef logic [1:0] ulpi_line_state_t;
  typedef logic [5:0] ulpi_reg_addr_t;

  // Link bus value when the link has nothing to say
  localparam ulpi_data_t ULPI_CMD_IDLE = 8'h00;

  // TX CMD prefixes, PID or register address fill the remaining bits
  localparam logic [3:0] ULPI_CMD_TRANSMIT = 4'h4;
  localparam logic [1:0] ULPI_CMD_REG_WRITE = 2'b10;

  // Fixed RX CMD fields, full-speed device with a valid VBUS
  localparam logic [1:0] RX_CMD_FIXED_HI = 2'b01;
  localparam logic [1:0] RX_CMD_VBUS = 2'b11;

  typedef struct packed {
    logic [1:0]       fixed_hi;
    logic             rx_error;
    logic             rx_active;
    logic [1:0]       vbus;
    ulpi_line_state_t line_state;
  } ulpi_rx_cmd_t;

  // Link to PHY half of the data bus
  typedef struct packed {
    ulpi_data_t data;
    logic       stp;
  } ulpi_link_bus_t;

  // PHY to link half, only meaningful while dir is high
  typedef struct packed {
    ulpi_data_t data;
    logic       dir;
    logic       nxt;
  } ulpi_phy_bus_t;

  typedef enum logic [2:0] {
    PHY_IDLE,
    PHY_REG_WRITE,
    PHY_WAIT,
    PHY_SEND,
    PHY_RECV,
    PHY_STOP,
    PHY_LINE,
    PHY_STAT
  } ulpi_phy_state_e;

  // Stands in for the 2.5 us line-state timer
  localparam int LINE_STATE_PERIOD = 150;
  localparam int LINE_COUNT_W = $clog2(LINE_STATE_PERIOD);

  // Stall when the LFSR lands above the threshold
  localparam logic [7:0] LFSR_SEED = 8'hb5;
  localparam logic [7:0] STALL_THRESHOLD = 8'd192;

endpackage

// File: source/usb_stream_pkg.sv
package usb_stream_pkg;

  // One byte of a USB packet
  typedef logic [7:0] usb_byte_t;

  // Packet identifier as carried in the low nibble
  typedef logic [3:0] usb_pid_t;

  // Ready travels next to this struct as a single bit
  typedef struct packed {
    logic      valid;
    logic      last;
    usb_byte_t data;
  } usb_stream_t;

  // On the wire the PID byte carries its own complement in the upper nibble
  function automatic usb_byte_t usb_pid_byte(usb_pid_t pid);
    return {~pid, pid};
  endfunction

  // The host side only gives the PID in the low nibble of the first byte
  function automatic usb_pid_t usb_byte_pid(usb_byte_t data);
    return data[3:0];
  endfunction

endpackage
